// File: Bender.yml
package:
  name: exmem_slice

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_types_pkg.sv
      - logic/pipe_types_pkg.sv
      - logic/execute_stage.sv
      - logic/pipe_latch.sv
      - logic/memory_stage.sv
      - logic/hazard_ctrl.sv
      - logic/exmem_slice.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/clock_gen.sv
      - test/exmem_slice_tb.sv

// File: exmem_slice.f
+incdir+logic
logic/cpu_types_pkg.sv
logic/pipe_types_pkg.sv
logic/execute_stage.sv
logic/pipe_latch.sv
logic/memory_stage.sv
logic/hazard_ctrl.sv
logic/exmem_slice.sv
test/clock_gen.sv
test/exmem_slice_tb.sv

// File: logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and address width
`define CPU_WORD_W 32

// Architectural register file size
`define CPU_REG_COUNT 32

// Data memory depth in words
`define CPU_DMEM_WORDS 64

`endif

// File: logic/cpu_types_pkg.sv
`include "cpu_settings.svh"

package cpu_types_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regbits_t;

	// MIPS primary opcodes, HALT takes the all-ones slot
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		ORI   = 6'h0d,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		SLLV = 6'h04,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_SLT   = 3'd4,
		ALU_SLL   = 3'd5,
		ALU_PASSB = 3'd6
	} aluop_t;

endpackage

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
	input  logic                     issue_valid,
	input  cpu_types_pkg::opcode_t   op,
	input  cpu_types_pkg::funct_t    funct,
	input  cpu_types_pkg::word_t     rs_val,
	input  cpu_types_pkg::word_t     rt_val,
	input  cpu_types_pkg::regbits_t  rt,
	input  cpu_types_pkg::regbits_t  rd,
	input  logic [15:0]              imm16,
	input  cpu_types_pkg::word_t     pc,
	output pipe_types_pkg::exmem_t   ex_out
);

	localparam int W = `CPU_WORD_W;

	cpu_types_pkg::aluop_t   alu_op;
	cpu_types_pkg::word_t    opnd_b;
	cpu_types_pkg::word_t    alu_res;
	cpu_types_pkg::word_t    imm_sext;
	cpu_types_pkg::word_t    pc_plus4;
	cpu_types_pkg::word_t    target;
	cpu_types_pkg::regbits_t wreg;
	logic reg_wen, mem_to_reg, dmem_wen, dmem_ren, taken, halt;

	assign imm_sext = {{(W-16){imm16[15]}}, imm16};
	assign pc_plus4 = pc + W'(4);

	// Control decode
	always_comb begin
		alu_op     = cpu_types_pkg::ALU_ADD;
		opnd_b     = rt_val;
		wreg       = rd;
		reg_wen    = 1'b0;
		mem_to_reg = 1'b0;
		dmem_wen   = 1'b0;
		dmem_ren   = 1'b0;
		taken      = 1'b0;
		halt       = 1'b0;
		target     = pc_plus4 + (imm_sext << 2);
		case (op)
			cpu_types_pkg::RTYPE: begin
				reg_wen = 1'b1;
				case (funct)
					cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
					cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
					cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
					cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
					cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
					cpu_types_pkg::SLLV: alu_op = cpu_types_pkg::ALU_SLL;
					default:             reg_wen = 1'b0;
				endcase
			end
			cpu_types_pkg::ADDIU: begin
				opnd_b  = imm_sext;
				wreg    = rt;
				reg_wen = 1'b1;
			end
			cpu_types_pkg::ORI: begin
				alu_op  = cpu_types_pkg::ALU_OR;
				opnd_b  = {{(W-16){1'b0}}, imm16};
				wreg    = rt;
				reg_wen = 1'b1;
			end
			cpu_types_pkg::LUI: begin
				alu_op  = cpu_types_pkg::ALU_PASSB;
				opnd_b  = {imm16, {(W-16){1'b0}}};
				wreg    = rt;
				reg_wen = 1'b1;
			end
			cpu_types_pkg::LW: begin
				opnd_b     = imm_sext;
				wreg       = rt;
				reg_wen    = 1'b1;
				mem_to_reg = 1'b1;
				dmem_ren   = 1'b1;
			end
			cpu_types_pkg::SW: begin
				opnd_b   = imm_sext;
				dmem_wen = 1'b1;
			end
			cpu_types_pkg::BEQ: taken = (rs_val == rt_val);
			cpu_types_pkg::BNE: taken = (rs_val != rt_val);
			cpu_types_pkg::J: begin
				// Only 16 bits of jump index reach this stage
				taken  = 1'b1;
				target = {pc_plus4[W-1:18], imm16, 2'b00};
			end
			cpu_types_pkg::HALT: halt = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (alu_op)
			cpu_types_pkg::ALU_ADD:   alu_res = rs_val + opnd_b;
			cpu_types_pkg::ALU_SUB:   alu_res = rs_val - opnd_b;
			cpu_types_pkg::ALU_AND:   alu_res = rs_val & opnd_b;
			cpu_types_pkg::ALU_OR:    alu_res = rs_val | opnd_b;
			cpu_types_pkg::ALU_SLT:   alu_res = W'($signed(rs_val) < $signed(opnd_b));
			cpu_types_pkg::ALU_SLL:   alu_res = opnd_b << rs_val[4:0];
			cpu_types_pkg::ALU_PASSB: alu_res = opnd_b;
			default:                  alu_res = '0;
		endcase
	end

	always_comb begin
		ex_out = '0;
		if (issue_valid) begin
			ex_out.valid        = 1'b1;
			ex_out.pcplus4      = pc_plus4;
			ex_out.target       = target;
			ex_out.alu_out      = alu_res;
			ex_out.store_data   = rt_val;
			ex_out.wreg         = wreg;
			ex_out.reg_wen      = reg_wen;
			ex_out.mem_to_reg   = mem_to_reg;
			ex_out.dmem_wen     = dmem_wen;
			ex_out.dmem_ren     = dmem_ren;
			ex_out.branch_taken = taken;
			ex_out.halt         = halt;
		end
	end

endmodule

// File: logic/exmem_slice.sv
`timescale 1ns/1ps

module exmem_slice (
	input  logic                     CLK,
	input  logic                     nRST,
	input  logic                     issue_valid,
	input  cpu_types_pkg::opcode_t   op,
	input  cpu_types_pkg::funct_t    funct,
	input  cpu_types_pkg::word_t     rs_val,
	input  cpu_types_pkg::word_t     rt_val,
	input  cpu_types_pkg::regbits_t  rt,
	input  cpu_types_pkg::regbits_t  rd,
	input  logic [15:0]              imm16,
	input  cpu_types_pkg::word_t     pc,
	input  logic                     stall,
	output logic                     wb_valid,
	output logic                     wb_reg_wen,
	output cpu_types_pkg::regbits_t  wb_reg,
	output cpu_types_pkg::word_t     wb_data,
	output logic                     redirect,
	output cpu_types_pkg::word_t     redirect_pc,
	output logic                     halted
);

	pipe_types_pkg::exmem_t ex_d;
	pipe_types_pkg::exmem_t exmem_q;
	pipe_types_pkg::memwb_t mem_d;
	pipe_types_pkg::memwb_t memwb_q;
	logic exmem_en, exmem_flush, memwb_en, store_en;

	execute_stage u_execute (
		.issue_valid (issue_valid),
		.op          (op),
		.funct       (funct),
		.rs_val      (rs_val),
		.rt_val      (rt_val),
		.rt          (rt),
		.rd          (rd),
		.imm16       (imm16),
		.pc          (pc),
		.ex_out      (ex_d)
	);

	pipe_latch #(.payload_t(pipe_types_pkg::exmem_t)) u_exmem (
		.CLK    (CLK),
		.nRST   (nRST),
		.flush  (exmem_flush),
		.enable (exmem_en),
		.d      (ex_d),
		.q      (exmem_q)
	);

	memory_stage u_memory (
		.CLK      (CLK),
		.nRST     (nRST),
		.store_en (store_en),
		.mem_in   (exmem_q),
		.wb_out   (mem_d)
	);

	// MEM/WB is never flushed
	pipe_latch #(.payload_t(pipe_types_pkg::memwb_t)) u_memwb (
		.CLK    (CLK),
		.nRST   (nRST),
		.flush  (1'b0),
		.enable (memwb_en),
		.d      (mem_d),
		.q      (memwb_q)
	);

	hazard_ctrl u_hazard (
		.CLK         (CLK),
		.nRST        (nRST),
		.stall       (stall),
		.exmem_q     (exmem_q),
		.wb_halt     (memwb_q.halt),
		.exmem_en    (exmem_en),
		.exmem_flush (exmem_flush),
		.memwb_en    (memwb_en),
		.store_en    (store_en),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted)
	);

	assign wb_valid   = memwb_q.valid;
	assign wb_reg_wen = memwb_q.reg_wen;
	assign wb_reg     = memwb_q.wreg;
	assign wb_data    = memwb_q.wdata;

endmodule

// File: logic/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   stall,
	input  pipe_types_pkg::exmem_t exmem_q,
	input  logic                   wb_halt,
	output logic                   exmem_en,
	output logic                   exmem_flush,
	output logic                   memwb_en,
	output logic                   store_en,
	output logic                   redirect,
	output cpu_types_pkg::word_t   redirect_pc,
	output logic                   halted
);

	logic halted_q;
	logic advance;
	logic halt_in_exmem;

	// Sticky until reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halted_q <= 1'b0;
		end else if (wb_halt) begin
			halted_q <= 1'b1;
		end
	end

	assign halted = halted_q | wb_halt;
	assign advance = !stall && !halted;

	assign halt_in_exmem = exmem_q.valid && exmem_q.halt;

	assign redirect    = exmem_q.valid && exmem_q.branch_taken;
	assign redirect_pc = exmem_q.target;

	// Wrong-path or post-halt instruction in execute is dropped
	assign exmem_flush = advance && (redirect || halt_in_exmem);
	assign exmem_en    = advance;
	assign memwb_en    = advance;
	assign store_en    = advance;

	// Halt squashes its successor, so EX/MEM is a bubble once halted
	a_no_redirect_halted: assert property (
		@(posedge CLK) disable iff (!nRST)
		halted |-> !redirect
	);

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   store_en,
	input  pipe_types_pkg::exmem_t mem_in,
	output pipe_types_pkg::memwb_t wb_out
);

	localparam int DEPTH  = `CPU_DMEM_WORDS;
	localparam int ADDR_W = $clog2(DEPTH);

	cpu_types_pkg::word_t mem [DEPTH];
	cpu_types_pkg::word_t load_data;
	logic [ADDR_W-1:0]    addr;
	logic                 do_store;

	// Word address, byte offset dropped
	assign addr = mem_in.alu_out[ADDR_W+1:2];

	assign do_store = store_en && mem_in.valid && mem_in.dmem_wen;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (do_store) begin
			mem[addr] <= mem_in.store_data;
		end
	end

	assign load_data = mem_in.dmem_ren ? mem[addr] : '0;

	always_comb begin
		wb_out         = '0;
		wb_out.valid   = mem_in.valid;
		wb_out.reg_wen = mem_in.reg_wen;
		wb_out.wreg    = mem_in.wreg;
		wb_out.wdata   = mem_in.mem_to_reg ? load_data : mem_in.alu_out;
		wb_out.halt    = mem_in.halt;
	end

	// Execute never marks one instruction as both load and store
	a_rw_exclusive: assert property (
		@(posedge CLK) disable iff (!nRST)
		mem_in.valid |-> !(mem_in.dmem_wen && mem_in.dmem_ren)
	);

endmodule

// File: logic/pipe_latch.sv
`timescale 1ns/1ps

module pipe_latch #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     flush,
	input  logic     enable,
	input  payload_t d,
	output payload_t q
);

	// Flush beats enable, bubble is all zero
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

	a_ctrl_known: assert property (
		@(posedge CLK) disable iff (!nRST)
		!$isunknown({flush, enable})
	);

endmodule

// File: logic/pipe_types_pkg.sv
`include "cpu_settings.svh"

package pipe_types_pkg;

	// All-zero value is a bubble
	typedef struct packed {
		logic                     valid;
		cpu_types_pkg::word_t     pcplus4;
		cpu_types_pkg::word_t     target;
		cpu_types_pkg::word_t     alu_out;
		cpu_types_pkg::word_t     store_data;
		cpu_types_pkg::regbits_t  wreg;
		logic                     reg_wen;
		logic                     mem_to_reg;
		logic                     dmem_wen;
		logic                     dmem_ren;
		logic                     branch_taken;
		logic                     halt;
	} exmem_t;

	typedef struct packed {
		logic                     valid;
		logic                     reg_wen;
		cpu_types_pkg::regbits_t  wreg;
		cpu_types_pkg::word_t     wdata;
		logic                     halt;
	} memwb_t;

endpackage

// File: test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Release on a falling edge, away from the stimulus point
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
	end

endmodule

// File: test/exmem_slice_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module exmem_slice_tb;

	localparam int LIMIT = 20;

	logic CLK, nRST, issue_valid, stall;
	cpu_types_pkg::opcode_t  op;
	cpu_types_pkg::funct_t   funct;
	cpu_types_pkg::word_t    rs_val, rt_val, pc, wb_data, redirect_pc;
	cpu_types_pkg::regbits_t rt, rd, wb_reg;
	logic [15:0] imm16;
	logic wb_valid, wb_reg_wen, redirect, halted;
	int word_errs = 0;
	int reg_errs = 0;
	int flag_errs = 0;
	int count_errs = 0;

	clock_gen clk0 (.CLK(CLK), .nRST(nRST));

	exmem_slice dut0 (.*);

	task automatic check_word(input string what, input cpu_types_pkg::word_t got, exp);
		if (got !== exp) begin
			word_errs++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input string what, input cpu_types_pkg::regbits_t got, exp);
		if (got !== exp) begin
			reg_errs++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, exp);
		if (got !== exp) begin
			flag_errs++;
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, exp);
		if (got != exp) begin
			count_errs++;
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("Errors: word %0d, reg %0d, flag %0d, count %0d",
			word_errs, reg_errs, flag_errs, count_errs);
	endtask

	task automatic abort_run(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		print_counts();
		$display("TEST FAIL");
		$finish;
	endtask

	// Stimulus and sampling point 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge CLK);
		#2;
	endtask

	task automatic drive_instr(input cpu_types_pkg::opcode_t o, input cpu_types_pkg::funct_t f,
			input cpu_types_pkg::word_t a, b, input cpu_types_pkg::regbits_t r_t, r_d,
			input logic [15:0] imm, input cpu_types_pkg::word_t p);
		op          = o;
		funct       = f;
		rs_val      = a;
		rt_val      = b;
		rt          = r_t;
		rd          = r_d;
		imm16       = imm;
		pc          = p;
		issue_valid = 1'b1;
	endtask

	task automatic wait_reset();
		int i;
		for (i = 0; i < LIMIT && nRST !== 1'b1; i++) begin
			next_cycle();
		end
		if (nRST !== 1'b1) begin
			abort_run("reset was never released");
		end
	endtask

	task automatic wait_wb(output int steps);
		for (steps = 0; steps < LIMIT && !wb_valid; steps++) begin
			next_cycle();
		end
		if (!wb_valid) begin
			abort_run("no writeback appeared before the timeout");
		end
	endtask

	// New writeback is an unstalled MEM/WB load or any rise of wb_valid
	task automatic advance_and_count(inout int n);
		logic was_stalled;
		logic was_valid;
		was_stalled = stall;
		was_valid = wb_valid;
		next_cycle();
		if (wb_valid && (!was_stalled || !was_valid)) begin
			n++;
		end
	endtask

	function automatic cpu_types_pkg::word_t model_rtype(input cpu_types_pkg::funct_t f,
			input cpu_types_pkg::word_t a, b);
		case (f)
			cpu_types_pkg::ADDU: return a + b;
			cpu_types_pkg::SUBU: return a - b;
			cpu_types_pkg::AND:  return a & b;
			cpu_types_pkg::OR:   return a | b;
			cpu_types_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpu_types_pkg::SLLV: return b << a[4:0];
			default:             return 'x;
		endcase
	endfunction

	// Destination is rd for R-type and rt otherwise
	task automatic run_instr(input cpu_types_pkg::opcode_t o, input cpu_types_pkg::funct_t f,
			input cpu_types_pkg::word_t a, b, input logic [15:0] imm,
			input logic exp_wen, input cpu_types_pkg::word_t exp);
		cpu_types_pkg::regbits_t r_t, r_d;
		int steps;
		r_t = 5'($urandom);
		r_d = r_t ^ 5'h15;
		drive_instr(o, f, a, b, r_t, r_d, imm, 32'h0040_0000);
		next_cycle();
		issue_valid = 1'b0;
		wait_wb(steps);
		check_count("writeback latency", steps + 1, 2);
		check_flag("wb_reg_wen", wb_reg_wen, exp_wen);
		if (exp_wen) begin
			check_reg("wb_reg", wb_reg, (o == cpu_types_pkg::RTYPE) ? r_d : r_t);
			check_word("wb_data", wb_data, exp);
		end
	endtask

	task automatic run_branch(input cpu_types_pkg::opcode_t o, input cpu_types_pkg::word_t a, b,
			input logic [15:0] imm, input cpu_types_pkg::word_t p, input logic taken,
			input cpu_types_pkg::word_t target);
		int steps;
		drive_instr(o, cpu_types_pkg::ADDU, a, b, 5'd1, 5'd2, imm, p);
		next_cycle();
		check_flag("redirect", redirect, taken);
		if (taken) begin
			check_word("redirect_pc", redirect_pc, target);
		end
		// Successor sits in execute while the branch is in EX/MEM
		drive_instr(cpu_types_pkg::RTYPE, cpu_types_pkg::ADDU, 32'd5, 32'd6, 5'd3, 5'd4,
			16'h0000, p + 32'd4);
		next_cycle();
		issue_valid = 1'b0;
		check_flag("redirect after branch", redirect, 1'b0);
		wait_wb(steps);
		check_flag("branch wb_reg_wen", wb_reg_wen, 1'b0);
		next_cycle();
		check_flag("successor wb_valid", wb_valid, !taken);
		if (!taken) begin
			check_word("successor wb_data", wb_data, model_rtype(cpu_types_pkg::ADDU, 5, 6));
		end
		next_cycle();
		check_flag("trailing wb_valid", wb_valid, 1'b0);
	endtask

	task automatic test_reset_and_rtype();
		cpu_types_pkg::funct_t fs [6];
		cpu_types_pkg::word_t a, b;
		fs = '{cpu_types_pkg::ADDU, cpu_types_pkg::SUBU, cpu_types_pkg::AND,
			cpu_types_pkg::OR, cpu_types_pkg::SLT, cpu_types_pkg::SLLV};
		check_flag("wb_valid after reset", wb_valid, 1'b0);
		check_flag("wb_reg_wen after reset", wb_reg_wen, 1'b0);
		check_flag("redirect after reset", redirect, 1'b0);
		check_flag("halted after reset", halted, 1'b0);
		foreach (fs[i]) begin
			a = $urandom;
			b = $urandom;
			run_instr(cpu_types_pkg::RTYPE, fs[i], a, b, 16'h0000, 1'b1, model_rtype(fs[i], a, b));
		end
	endtask

	task automatic test_immediates();
		cpu_types_pkg::word_t a;
		logic [15:0] imm;
		a = $urandom;
		imm = 16'($urandom);
		run_instr(cpu_types_pkg::ADDIU, cpu_types_pkg::ADDU, a, '0, imm, 1'b1,
			a + {{16{imm[15]}}, imm});
		run_instr(cpu_types_pkg::ORI, cpu_types_pkg::ADDU, a, '0, imm, 1'b1, a | {16'h0000, imm});
		run_instr(cpu_types_pkg::LUI, cpu_types_pkg::ADDU, a, '0, imm, 1'b1, {imm, 16'h0000});
		run_instr(cpu_types_pkg::ADDIU, cpu_types_pkg::ADDU, a, '0, 16'h8001, 1'b1, a - 32'h7fff);
	endtask

	task automatic test_store_load();
		cpu_types_pkg::word_t data;
		data = $urandom;
		run_instr(cpu_types_pkg::SW, cpu_types_pkg::ADDU, 32'h40, data, 16'h0008, 1'b0, '0);
		run_instr(cpu_types_pkg::LW, cpu_types_pkg::ADDU, 32'h50, '0, 16'hfff8, 1'b1, data);
		// Never written so still zero from reset
		run_instr(cpu_types_pkg::LW, cpu_types_pkg::ADDU, 32'h0, '0,
			16'(4 * (`CPU_DMEM_WORDS - 1)), 1'b1, '0);
	endtask

	task automatic test_branches();
		cpu_types_pkg::word_t a, p;
		logic [15:0] imm;
		a = $urandom;
		imm = 16'($urandom);
		p = 32'h0040_1000;
		run_branch(cpu_types_pkg::BEQ, a, a, imm, p, 1'b1, p + 32'd4 + {{14{imm[15]}}, imm, 2'b00});
		imm = 16'($urandom);
		p = p + 32'd4;
		run_branch(cpu_types_pkg::J, '0, '0, imm, p, 1'b1, {p[31:18] + 14'(p[17:0] > 18'h3fffb),
			imm, 2'b00});
		run_branch(cpu_types_pkg::BNE, a, a, imm, p + 32'd8, 1'b0, '0);
	endtask

	task automatic test_stall();
		cpu_types_pkg::word_t data, a, b;
		int n, i;
		data = $urandom;
		a = $urandom;
		b = $urandom;
		n = 0;
		drive_instr(cpu_types_pkg::SW, cpu_types_pkg::ADDU, 32'h20, data, 5'd1, 5'd2, 16'h0000,
			32'h0040_3000);
		advance_and_count(n);
		issue_valid = 1'b0;
		stall = 1'b1;
		repeat (4) advance_and_count(n);
		check_count("writebacks while store is stalled", n, 0);
		stall = 1'b0;
		drive_instr(cpu_types_pkg::RTYPE, cpu_types_pkg::ADDU, a, b, 5'd1, 5'd12, 16'h0000,
			32'h0040_3004);
		advance_and_count(n);
		check_count("writebacks after store", n, 1);
		issue_valid = 1'b0;
		stall = 1'b1;
		repeat (3) advance_and_count(n);
		check_flag("held store wb_reg_wen", wb_reg_wen, 1'b0);
		stall = 1'b0;
		for (i = 0; i < LIMIT && n < 2; i++) begin
			advance_and_count(n);
		end
		if (n < 2) begin
			abort_run("ADDU never wrote back after the stall");
		end
		check_reg("stalled ADDU wb_reg", wb_reg, 5'd12);
		check_word("stalled ADDU wb_data", wb_data, model_rtype(cpu_types_pkg::ADDU, a, b));
		repeat (3) advance_and_count(n);
		check_count("writebacks in stall sequence", n, 2);
		run_instr(cpu_types_pkg::LW, cpu_types_pkg::ADDU, 32'h10, '0, 16'h0010, 1'b1, data);
	endtask

	task automatic test_halt();
		drive_instr(cpu_types_pkg::HALT, cpu_types_pkg::ADDU, '0, '0, 5'd1, 5'd2, 16'h0000,
			32'h0040_2000);
		next_cycle();
		check_flag("halted before retire", halted, 1'b0);
		drive_instr(cpu_types_pkg::RTYPE, cpu_types_pkg::ADDU, 32'd1, 32'd2, 5'd3, 5'd20,
			16'h0000, 32'h0040_2004);
		next_cycle();
		check_flag("halted", halted, 1'b1);
		// Issuing continues but nothing may retire
		repeat (6) begin
			check_flag("wb_reg_wen after halt", wb_reg_wen, 1'b0);
			check_flag("halted held", halted, 1'b1);
			check_flag("redirect after halt", redirect, 1'b0);
			next_cycle();
		end
		issue_valid = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h307a68c4));
		issue_valid = 1'b0;
		stall = 1'b0;
		op = cpu_types_pkg::RTYPE;
		funct = cpu_types_pkg::ADDU;
		rs_val = '0;
		rt_val = '0;
		rt = '0;
		rd = '0;
		imm16 = '0;
		pc = '0;
		wait_reset();
		test_reset_and_rtype();
		test_immediates();
		test_store_load();
		test_branches();
		test_stall();
		test_halt();
		print_counts();
		if (word_errs + reg_errs + flag_errs + count_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
